//--- common/fetch_pkg.sv
package fetch_pkg;

    // fetch blocks are two words, aligned to 8 bytes
    localparam int BLOCK_BYTES = 8;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_entry_t;

    // lower word at pc, upper word at pc+4 only when valid2
    typedef struct packed {
        logic        valid2;
        logic [31:0] pc;
        logic [63:0] data;
    } fetch_block_t;

    typedef struct packed {
        fetch_entry_t slot0;
        fetch_entry_t slot1;
        logic [1:0]   count;
    } issue_pair_t;

    function automatic logic [4:0] rd_of(input logic [31:0] instr);
        return instr[11:7];
    endfunction

    function automatic logic [4:0] rs1_of(input logic [31:0] instr);
        return instr[19:15];
    endfunction

    function automatic logic [4:0] rs2_of(input logic [31:0] instr);
        return instr[24:20];
    endfunction

endpackage

//--- src/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl
    import fetch_pkg::*;
#(
    parameter int          DEPTH    = 16,
    parameter logic [31:0] RESET_PC = 32'h0000_1004,
    localparam int         LW       = $clog2(DEPTH + 1)
) (
    input  logic          clk,
    input  logic          rstn,
    input  logic [LW-1:0] level,
    input  logic [1:0]    pop_count,
    input  logic          imem_ack,
    input  logic [63:0]   imem_rdata,
    output logic          imem_req,
    output logic [31:0]   imem_addr,
    output logic          push,
    output fetch_block_t  push_blk
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_DRAIN
    } state_t;

    state_t      state;
    logic [31:0] pc;
    logic [LW:0] free_after_pop;
    logic        space_ok;
    logic        xfer_done;

    // free entries once this cycle's pop has left
    assign free_after_pop = (LW + 1)'(DEPTH) - {1'b0, level} + (LW + 1)'(pop_count);
    assign space_ok       = free_after_pop >= (LW + 1)'(2);
    assign xfer_done      = (state == S_WAIT) && imem_ack;

    assign imem_addr = {pc[31:3], 3'b000};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= S_IDLE;
            pc       <= RESET_PC;
            imem_req <= 1'b0;
            push     <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                S_IDLE: begin
                    // previous ack must be gone before a new req
                    if (space_ok && !imem_ack) begin
                        imem_req <= 1'b1;
                        state    <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (imem_ack) begin
                        imem_req <= 1'b0;
                        push     <= 1'b1;
                        pc       <= {pc[31:3], 3'b000} + BLOCK_BYTES;
                        state    <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    if (!imem_ack) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // on an odd word start only the upper half is wanted and it moves down to slot 0
    always_ff @(posedge clk) begin
        if (xfer_done) begin
            push_blk.pc <= pc;
            if (pc[2]) begin
                push_blk.valid2 <= 1'b0;
                push_blk.data   <= {32'h0, imem_rdata[63:32]};
            end else begin
                push_blk.valid2 <= 1'b1;
                push_blk.data   <= imem_rdata;
            end
        end
    end

    a_req_held: assert property (@(posedge clk) disable iff (!rstn)
        imem_req && !imem_ack |=> imem_req)
        else $error("imem_req dropped before ack");

    // pops only shrink the buffer while a request is in flight
    a_push_space: assert property (@(posedge clk) disable iff (!rstn)
        push |-> free_after_pop >= (LW + 1)'(2))
        else $error("push without two free entries");

endmodule

//--- fetch_buffer/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer
    import fetch_pkg::*;
#(
    parameter int  DEPTH = 16,
    localparam int LW    = $clog2(DEPTH + 1)
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               push,
    input  fetch_block_t       push_blk,
    input  logic [1:0]         pop_count,
    output fetch_entry_t [1:0] head,
    output logic [LW-1:0]      level
);

    if (DEPTH < 4 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
        $error("fetch_buffer DEPTH must be a power of two, at least 4");
    end

    fetch_entry_t  q      [DEPTH];
    fetch_entry_t  q_next [DEPTH];
    // three zero entries past the end so a shifted read stays in range
    fetch_entry_t  q_pad  [DEPTH + 3];
    fetch_entry_t  in_lo;
    fetch_entry_t  in_hi;
    logic [1:0]    push_n;
    logic [LW-1:0] keep;

    assign in_lo.pc    = push_blk.pc;
    assign in_lo.instr = push_blk.data[31:0];
    assign in_hi.pc    = push_blk.pc + 32'd4;
    assign in_hi.instr = push_blk.data[63:32];

    assign push_n = !push ? 2'd0 : (push_blk.valid2 ? 2'd2 : 2'd1);

    // survivors after this cycle's pop
    assign keep = level - LW'(pop_count);

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            q_pad[i] = q[i];
        end
        for (int i = DEPTH; i < DEPTH + 3; i++) begin
            q_pad[i] = '0;
        end
    end

    // shift survivors down, append pushed words right behind them
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            if (i < keep) begin
                q_next[i] = q_pad[i + pop_count];
            end else if (push && i == keep) begin
                q_next[i] = in_lo;
            end else if (push && push_blk.valid2 && i == keep + 1) begin
                q_next[i] = in_hi;
            end else begin
                q_next[i] = '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            level <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                q[i] <= '0;
            end
        end else begin
            level <= keep + LW'(push_n);
            for (int i = 0; i < DEPTH; i++) begin
                q[i] <= q_next[i];
            end
        end
    end

    assign head[0] = q[0];
    assign head[1] = q[1];

    a_pop_in_range: assert property (@(posedge clk) disable iff (!rstn)
        pop_count <= level)
        else $error("pop_count %0d exceeds level %0d", pop_count, level);

    // relies on the requester's space check
    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        push |-> int'(level) + int'(push_n) <= DEPTH)
        else $error("push overflows buffer at level %0d", level);

endmodule

//--- src/issue_select.sv
`timescale 1ns/1ps

module issue_select
    import fetch_pkg::*;
#(
    parameter int  DEPTH = 16,
    localparam int LW    = $clog2(DEPTH + 1)
) (
    input  fetch_entry_t [1:0] head,
    input  logic [LW-1:0]      level,
    input  logic               stall,
    output logic [1:0]         pop_count,
    output issue_pair_t        issue
);

    logic [4:0] rd0;
    logic [4:0] rs1_1;
    logic [4:0] rs2_1;
    logic       dep;
    logic [1:0] count;

    assign rd0   = rd_of(head[0].instr);
    assign rs1_1 = rs1_of(head[1].instr);
    assign rs2_1 = rs2_of(head[1].instr);

    // x0 writes never create a hazard
    assign dep = (rd0 != 5'd0) && (rd0 == rs1_1 || rd0 == rs2_1);

    always_comb begin
        if (stall || level == '0) begin
            count = 2'd0;
        end else if (level >= LW'(2) && !dep) begin
            count = 2'd2;
        end else begin
            count = 2'd1;
        end
    end

    assign pop_count   = count;
    assign issue.slot0 = head[0];
    assign issue.slot1 = head[1];
    assign issue.count = count;

    // a dual issue is always two consecutive words
    always_comb begin
        a_pair_contiguous: assert (count != 2'd2 || head[1].pc == head[0].pc + 32'd4)
            else $error("dual issue of pcs %h and %h", head[0].pc, head[1].pc);
    end

endmodule

//--- src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter int          DEPTH    = 16,
    parameter logic [31:0] RESET_PC = 32'h0000_1004
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        stall,
    input  logic        imem_ack,
    input  logic [63:0] imem_rdata,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    output issue_pair_t issue
);

    localparam int LW = $clog2(DEPTH + 1);

    logic               push;
    fetch_block_t       push_blk;
    logic [LW-1:0]      level;
    fetch_entry_t [1:0] head;
    logic [1:0]         pop_count;

    fetch_ctrl #(
        .DEPTH    (DEPTH),
        .RESET_PC (RESET_PC)
    ) i_fetch_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .level      (level),
        .pop_count  (pop_count),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .push       (push),
        .push_blk   (push_blk)
    );

    fetch_buffer #(
        .DEPTH (DEPTH)
    ) i_fetch_buffer (
        .clk       (clk),
        .rstn      (rstn),
        .push      (push),
        .push_blk  (push_blk),
        .pop_count (pop_count),
        .head      (head),
        .level     (level)
    );

    issue_select #(
        .DEPTH (DEPTH)
    ) i_issue_select (
        .head      (head),
        .level     (level),
        .stall     (stall),
        .pop_count (pop_count),
        .issue     (issue)
    );

endmodule

//--- sim/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch
    import fetch_pkg::*;
();

    localparam int          CLK_PERIOD     = 10;
    localparam int          DEPTH          = 16;
    localparam logic [31:0] RESET_PC       = 32'h0000_1004;
    localparam int          NUM_INSTR      = 2000;
    localparam int          TIMEOUT_CYCLES = NUM_INSTR * 20 + 16;

    logic        clk;
    logic        rstn;
    logic        stall;
    logic        imem_ack;
    logic [63:0] imem_rdata;
    logic        imem_req;
    logic [31:0] imem_addr;
    issue_pair_t issue;

    // memory responder state
    logic [31:0] rng;
    logic [1:0]  ack_delay;
    logic        waiting;

    // monitor model
    int          occ;
    int          landing;
    int          exp_count;
    int          checked;
    logic [31:0] exp_pc;
    logic [31:0] fetch_pc;
    logic        prev_req;
    logic        prev_ack;
    logic [31:0] prev_addr;
    logic        after_reset;

    fetch_top #(
        .DEPTH    (DEPTH),
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .imem_ack   (imem_ack),
        .imem_rdata (imem_rdata),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .issue      (issue)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // r-type words on x0..x3 only so hazards are common
    function automatic logic [31:0] ref_instr(input logic [31:0] pc);
        logic [31:0] h;
        h = pc * 32'h9e37_79b1;
        h = h ^ (h >> 15);
        return {pc[8:2], 3'b000, h[1:0], 3'b000, h[5:4], 3'b000, 3'b000, h[9:8], 7'h33};
    endfunction

    function automatic logic [63:0] block_at(input logic [31:0] addr);
        return {ref_instr(addr + 32'd4), ref_instr(addr)};
    endfunction

    function automatic int expected_count(input logic stalled, input int avail,
                                          input logic [31:0] pc);
        logic [31:0] first;
        logic [31:0] second;
        logic        dependent;
        first     = ref_instr(pc);
        second    = ref_instr(pc + 32'd4);
        dependent = (rd_of(first) != 5'd0) &&
                    (rd_of(first) == rs1_of(second) || rd_of(first) == rs2_of(second));
        if (stalled || avail == 0) begin
            return 0;
        end else if (avail >= 2 && !dependent) begin
            return 2;
        end
        return 1;
    endfunction

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("** Error [%s] expected %h, actual %h at %0t", test, expected, actual, $time);
        $display("sim failed");
        $fatal(1, "mismatch in %s", test);
    endtask

    task automatic report_failure(input string what);
        $display("handshake problem at %0t: %s", $time, what);
        $display("sim failed");
        $fatal(1, "%s", what);
    endtask

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        stall      = 1'b0;
        imem_ack   = 1'b0;
        imem_rdata = '0;
        rng        = 32'hcd366025;
        ack_delay  = '0;
        waiting    = 1'b0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
    end

    // memory responder and random stall
    always @(posedge clk) begin
        if (!rstn) begin
            imem_ack <= 1'b0;
            stall    <= 1'b0;
            waiting  = 1'b0;
        end else begin
            rng = lcg_next(rng);
            stall <= (rng[31:30] == 2'b00);
            if (imem_ack && !imem_req) begin
                imem_ack <= 1'b0;
            end else if (imem_req && !imem_ack) begin
                if (!waiting) begin
                    rng       = lcg_next(rng);
                    ack_delay = rng[29:28];
                    waiting   = 1'b1;
                end
                if (ack_delay == 2'd0) begin
                    imem_ack   <= 1'b1;
                    imem_rdata <= block_at(imem_addr);
                    waiting    = 1'b0;
                end else begin
                    ack_delay = ack_delay - 2'd1;
                end
            end
        end
    end

    // outputs sampled mid-cycle and model advanced once per cycle
    always @(negedge clk) begin
        if (!rstn) begin
            assert (!imem_req) else report_failure("imem_req is high during reset");
            assert (issue.count == 2'd0)
                else report_mismatch("reset_count", 32'd0, 32'(issue.count));
            occ         = 0;
            landing     = 0;
            checked     = 0;
            exp_pc      = RESET_PC;
            fetch_pc    = RESET_PC;
            prev_req    = 1'b0;
            prev_ack    = 1'b0;
            prev_addr   = '0;
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                assert (!imem_req) else report_failure("imem_req is high right after reset");
                after_reset = 1'b0;
            end
            if (prev_req && !imem_req) begin
                assert (prev_ack) else report_failure("imem_req fell before imem_ack was seen");
            end
            if (!prev_req && imem_req) begin
                assert (!prev_ack) else report_failure("imem_req rose while imem_ack was high");
            end
            if (imem_req) begin
                assert (imem_addr[2:0] == 3'b000)
                    else report_mismatch("addr_align", 32'd0, 32'(imem_addr[2:0]));
                if (prev_req) begin
                    assert (imem_addr == prev_addr)
                        else report_mismatch("addr_stable", prev_addr, imem_addr);
                end else begin
                    assert (imem_addr == {fetch_pc[31:3], 3'b000})
                        else report_mismatch("addr_sequence", {fetch_pc[31:3], 3'b000}, imem_addr);
                end
            end

            exp_count = expected_count(stall, occ, exp_pc);
            assert (int'(issue.count) == exp_count)
                else report_mismatch(stall ? "stall" : "pairing", 32'(exp_count),
                                     32'(issue.count));
            // head must hold the next instruction even while stalled
            if (occ > 0) begin
                assert (issue.slot0.pc == exp_pc)
                    else report_mismatch(checked == 0 ? "misaligned_start" : "in_order_pc",
                                         exp_pc, issue.slot0.pc);
                assert (issue.slot0.instr == ref_instr(exp_pc))
                    else report_mismatch("in_order_instr", ref_instr(exp_pc), issue.slot0.instr);
            end
            if (exp_count == 2) begin
                assert (issue.slot1.pc == exp_pc + 32'd4)
                    else report_mismatch("pair_pc", exp_pc + 32'd4, issue.slot1.pc);
                assert (issue.slot1.instr == ref_instr(exp_pc + 32'd4))
                    else report_mismatch("pair_instr", ref_instr(exp_pc + 32'd4),
                                         issue.slot1.instr);
            end

            checked = checked + exp_count;
            exp_pc  = exp_pc + 32'(4 * exp_count);
            occ     = occ - exp_count + landing;
            landing = 0;
            // ack seen now means a push next cycle and entries visible the cycle after
            if (imem_req && imem_ack) begin
                landing  = fetch_pc[2] ? 1 : 2;
                fetch_pc = {fetch_pc[31:3], 3'b000} + 32'd8;
            end
            prev_req  = imem_req;
            prev_ack  = imem_ack;
            prev_addr = imem_addr;

            if (checked >= NUM_INSTR) begin
                $display("sim passed");
                $finish;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: only %0d of %0d instructions issued", checked, NUM_INSTR);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- files.f
common/fetch_pkg.sv
src/fetch_ctrl.sv
fetch_buffer/fetch_buffer.sv
src/issue_select.sv
src/fetch_top.sv
sim/tb_fetch.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_fetch \
    -Mdir build -o tb_fetch > build/compile.log 2>&1 \
    && ./build/tb_fetch > build/sim.log 2>&1 \
    || echo "compile or simulation ended with an error, see build/"

grep -qs '^sim passed$' build/sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
